//--- verilog/vga_pkg.sv
package vga_pkg;

    // Horizontal timing in pixels, 640x480 at 60 Hz
    localparam logic [9:0] H_ACTIVE = 10'd640;
    localparam logic [9:0] H_FRONT  = 10'd16;
    localparam logic [9:0] H_SYNC   = 10'd96;
    localparam logic [9:0] H_BACK   = 10'd48;
    localparam logic [9:0] H_TOTAL  = 10'd800;

    // Vertical timing in lines
    localparam logic [9:0] V_ACTIVE = 10'd480;
    localparam logic [9:0] V_FRONT  = 10'd10;
    localparam logic [9:0] V_SYNC   = 10'd2;
    localparam logic [9:0] V_BACK   = 10'd33;
    localparam logic [9:0] V_TOTAL  = 10'd525;

    // Two bits each of red, green, blue
    typedef logic [5:0] pixel_t;

    // Current scan position plus visible-area flag
    typedef struct packed {
        logic [9:0] col;
        logic [9:0] row;
        logic       active;   // High inside 640x480
    } pixel_pos_t;

endpackage

//--- verilog/game_pkg.sv
package game_pkg;

    import vga_pkg::*;

    typedef enum logic {
        PLAYING,
        WON
    } frog_state_e;

    // Same bit order as the board's button bundle
    typedef struct packed {
        logic right;
        logic up;
        logic down;
        logic left;
    } dpad_t;

    // Top-left corner of the frog square
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
    } frog_pos_t;

    // Layer colours
    localparam pixel_t FROG_COLOR  = 6'b001100;   // Green
    localparam pixel_t GOAL_COLOR  = 6'b000011;   // Blue
    localparam pixel_t ROAD_COLOR  = 6'b010101;   // Grey
    localparam pixel_t GRASS_COLOR = 6'b000100;   // Dark green

    // First row of the road band
    localparam logic [9:0] ROAD_TOP = 10'd224;

endpackage

//--- verilog/vga_timing.sv
`timescale 1ns/1ns

module vga_timing (
    input  logic                clk,
    input  logic                rst_n,
    output vga_pkg::pixel_pos_t pixel_pos,
    output logic                hsync,
    output logic                vsync
);

    import vga_pkg::*;

    localparam logic [9:0] hsync_start = H_ACTIVE + H_FRONT;
    localparam logic [9:0] hsync_end   = H_ACTIVE + H_FRONT + H_SYNC;
    localparam logic [9:0] vsync_start = V_ACTIVE + V_FRONT;
    localparam logic [9:0] vsync_end   = V_ACTIVE + V_FRONT + V_SYNC;

    logic [9:0] col;
    logic [9:0] row;
    logic       col_wrap;
    logic       row_wrap;
    logic       hsync_pulse;
    logic       vsync_pulse;

    assign col_wrap = (col == H_TOTAL - 10'd1);
    assign row_wrap = (row == V_TOTAL - 10'd1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col <= '0;
            row <= '0;
        end else begin
            if (col_wrap) begin
                col <= '0;
                // Row steps once per line
                if (row_wrap) begin
                    row <= '0;
                end else begin
                    row <= row + 10'd1;
                end
            end else begin
                col <= col + 10'd1;
            end
        end
    end

    // Counter view, not registered
    assign pixel_pos.col    = col;
    assign pixel_pos.row    = row;
    assign pixel_pos.active = (col < H_ACTIVE) && (row < V_ACTIVE);

    assign hsync_pulse = (col >= hsync_start) && (col < hsync_end);
    assign vsync_pulse = (row >= vsync_start) && (row < vsync_end);

    // One cycle late so the syncs line up with the registered layer colours
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
        end else begin
            hsync <= ~hsync_pulse;   // Active low
            vsync <= ~vsync_pulse;
        end
    end

endmodule

//--- verilog/frog_ctrl.sv
`timescale 1ns/1ns

module frog_ctrl #(
    parameter int init_x    = 320,
    parameter int init_y    = 448,
    parameter int frog_size = 32
) (
    input  logic               clk,
    input  logic               rst_n,
    input  game_pkg::dpad_t    dpad,
    output game_pkg::frog_pos_t frog_pos,
    output logic               reached_end
);

    import vga_pkg::*;
    import game_pkg::*;

    localparam logic [9:0]  step       = 10'(frog_size);
    localparam logic [10:0] double_step = {step, 1'b0};
    localparam frog_pos_t   start_pos  = '{x: 10'(init_x), y: 10'(init_y)};

    dpad_t       dpad_q;      // Buttons after one register
    dpad_t       dpad_prev;   // Previous sample for edge detection
    dpad_t       press;       // Rising edges, one cycle wide
    logic        any_press;
    frog_state_e state;
    frog_pos_t   move_pos;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dpad_q    <= '0;
            dpad_prev <= '0;
            press     <= '0;
        end else begin
            dpad_q    <= dpad;
            dpad_prev <= dpad_q;
            press     <= dpad_t'(dpad_q & ~dpad_prev);
        end
    end

    assign any_press = |press;

    // Target position for the winning press, bounds checked
    always_comb begin
        move_pos = frog_pos;
        if (press.up) begin
            if (frog_pos.y >= step) begin
                move_pos.y = frog_pos.y - step;
            end
        end else if (press.down) begin
            if ({1'b0, frog_pos.y} + double_step <= {1'b0, V_ACTIVE}) begin
                move_pos.y = frog_pos.y + step;
            end
        end else if (press.left) begin
            if (frog_pos.x >= step) begin
                move_pos.x = frog_pos.x - step;
            end
        end else if (press.right) begin
            if ({1'b0, frog_pos.x} + double_step <= {1'b0, H_ACTIVE}) begin
                move_pos.x = frog_pos.x + step;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= PLAYING;
            frog_pos <= start_pos;
        end else if (any_press) begin
            case (state)
                PLAYING: begin
                    frog_pos <= move_pos;
                    if (move_pos.y == '0) begin
                        state <= WON;   // Top row reached
                    end
                end
                WON: begin
                    // Any press starts a new round
                    frog_pos <= start_pos;
                    state    <= PLAYING;
                end
                default: state <= PLAYING;
            endcase
        end
    end

    assign reached_end = (state == WON);

endmodule

//--- verilog/frog_gen.sv
`timescale 1ns/1ns

module frog_gen #(
    parameter int frog_size = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    input  vga_pkg::pixel_pos_t pixel_pos,
    input  game_pkg::frog_pos_t frog_pos,
    output vga_pkg::pixel_t     color
);

    import game_pkg::*;

    localparam logic [10:0] size = 11'(frog_size);

    logic [10:0] x_end;   // One past the right edge
    logic [10:0] y_end;   // One past the bottom edge
    logic        in_x;
    logic        in_y;

    assign x_end = {1'b0, frog_pos.x} + size;
    assign y_end = {1'b0, frog_pos.y} + size;

    assign in_x = (pixel_pos.col >= frog_pos.x) && ({1'b0, pixel_pos.col} < x_end);
    assign in_y = (pixel_pos.row >= frog_pos.y) && ({1'b0, pixel_pos.row} < y_end);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            color <= '0;
        end else if (pixel_pos.active && in_x && in_y) begin
            color <= FROG_COLOR;
        end else begin
            color <= '0;   // Transparent
        end
    end

endmodule

//--- verilog/window_grid.sv
`timescale 1ns/1ns

module window_grid #(
    parameter int frog_size = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    input  vga_pkg::pixel_pos_t pixel_pos,
    output vga_pkg::pixel_t     color
);

    import game_pkg::*;

    // Strip is one frog tall so a frog in row 0 sits inside it
    localparam logic [9:0] strip_rows = 10'(frog_size);

    logic in_strip;
    logic on_post;

    assign in_strip = pixel_pos.active && (pixel_pos.row < strip_rows);

    // Posts every 64 columns
    assign on_post = (pixel_pos.col[5:0] == 6'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            color <= '0;
        end else if (in_strip && !on_post) begin
            color <= GOAL_COLOR;
        end else begin
            color <= '0;
        end
    end

endmodule

//--- verilog/background.sv
`timescale 1ns/1ns

module background (
    input  logic                clk,
    input  logic                rst_n,
    input  vga_pkg::pixel_pos_t pixel_pos,
    output vga_pkg::pixel_t     color
);

    import vga_pkg::*;
    import game_pkg::*;

    // Road stops one frog row above the bottom, leaving the start lane as grass
    localparam logic [9:0] road_end = V_ACTIVE - 10'd32;

    logic on_road;

    assign on_road = (pixel_pos.row >= ROAD_TOP) && (pixel_pos.row < road_end);

    // Lowest layer, so this is where the picture gets blanked
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            color <= '0;
        end else if (!pixel_pos.active) begin
            color <= '0;
        end else if (on_road) begin
            color <= ROAD_COLOR;
        end else begin
            color <= GRASS_COLOR;
        end
    end

endmodule

//--- verilog/frogger_top.sv
`timescale 1ns/1ns

module frogger_top #(
    parameter int init_x    = 320,
    parameter int init_y    = 448,   // Bottom lane
    parameter int frog_size = 32
) (
    input  logic                clk,   // 25 MHz pixel clock
    input  logic                rst_n,
    input  logic                button_up,
    input  logic                button_down,
    input  logic                button_left,
    input  logic                button_right,
    output logic                hsync,
    output logic                vsync,
    output vga_pkg::pixel_t     color,
    output game_pkg::frog_pos_t frog_pos,
    output logic                reached_end
);

    import vga_pkg::*;
    import game_pkg::*;

    pixel_pos_t pixel_pos;
    dpad_t      dpad;
    pixel_t     frog_color;
    pixel_t     goal_color;
    pixel_t     bg_color;

    assign dpad = '{right: button_right, up: button_up, down: button_down, left: button_left};

    vga_timing u_vga_timing (
        .clk       (clk),
        .rst_n     (rst_n),
        .pixel_pos (pixel_pos),
        .hsync     (hsync),
        .vsync     (vsync)
    );

    frog_ctrl #(
        .init_x    (init_x),
        .init_y    (init_y),
        .frog_size (frog_size)
    ) u_frog_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .dpad        (dpad),
        .frog_pos    (frog_pos),
        .reached_end (reached_end)
    );

    frog_gen #(
        .frog_size (frog_size)
    ) u_frog_gen (
        .clk       (clk),
        .rst_n     (rst_n),
        .pixel_pos (pixel_pos),
        .frog_pos  (frog_pos),
        .color     (frog_color)
    );

    window_grid #(
        .frog_size (frog_size)
    ) u_window_grid (
        .clk       (clk),
        .rst_n     (rst_n),
        .pixel_pos (pixel_pos),
        .color     (goal_color)
    );

    background u_background (
        .clk       (clk),
        .rst_n     (rst_n),
        .pixel_pos (pixel_pos),
        .color     (bg_color)
    );

    // Frog over goal strip over background, zero means transparent
    always_comb begin
        if (frog_color != '0) begin
            color = frog_color;
        end else if (goal_color != '0) begin
            color = goal_color;
        end else begin
            color = bg_color;
        end
    end

endmodule

//--- testbench/frogger_chk.sv
`timescale 1ns/1ns

module frogger_chk #(
    parameter int init_x    = 320,
    parameter int init_y    = 448,
    parameter int frog_size = 32
) (
    input logic                clk,
    input logic                rst_n,
    input logic                button_up,
    input logic                button_down,
    input logic                button_left,
    input logic                button_right,
    input logic                hsync,
    input logic                vsync,
    input game_pkg::frog_pos_t frog_pos,
    input logic                reached_end
);

    import game_pkg::*;

    localparam frog_pos_t start_pos = '{x: 10'(init_x), y: 10'(init_y)};

    int          fail_count = 0;   // Read by the testbench
    logic        hsync_q;
    logic        vsync_q;
    logic        h_fall;
    logic        h_rise;
    logic        v_fall;
    logic        v_rise;
    logic        h_seen;
    logic        v_seen;
    logic [19:0] h_low_len;
    logic [19:0] h_gap;
    logic [19:0] v_low_len;
    logic [19:0] v_gap;
    logic [3:0]  btn_q;      // up, down, left, right
    logic [3:0]  btn_prev;
    logic [3:0]  press;
    frog_pos_t   exp_pos;
    frog_pos_t   next_pos;
    logic        exp_won;

    assign h_fall = hsync_q && !hsync;
    assign h_rise = !hsync_q && hsync;
    assign v_fall = vsync_q && !vsync;
    assign v_rise = !vsync_q && vsync;

    // Pulse widths and spacing in clock cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync_q   <= 1'b1;
            vsync_q   <= 1'b1;
            h_seen    <= 1'b0;
            v_seen    <= 1'b0;
            h_low_len <= '0;
            h_gap     <= '0;
            v_low_len <= '0;
            v_gap     <= '0;
        end else begin
            hsync_q   <= hsync;
            vsync_q   <= vsync;
            h_low_len <= hsync ? 20'd0 : h_low_len + 20'd1;
            v_low_len <= vsync ? 20'd0 : v_low_len + 20'd1;
            h_gap     <= h_fall ? 20'd1 : h_gap + 20'd1;
            v_gap     <= v_fall ? 20'd1 : v_gap + 20'd1;
            if (h_fall) h_seen <= 1'b1;
            if (v_fall) v_seen <= 1'b1;
        end
    end

    // Step by one frog size when the frog stays fully on screen
    always_comb begin
        next_pos = exp_pos;
        if (press[3]) begin
            if (int'(exp_pos.y) >= frog_size) next_pos.y = exp_pos.y - 10'(frog_size);
        end else if (press[2]) begin
            if (int'(exp_pos.y) + 2 * frog_size <= 480) next_pos.y = exp_pos.y + 10'(frog_size);
        end else if (press[1]) begin
            if (int'(exp_pos.x) >= frog_size) next_pos.x = exp_pos.x - 10'(frog_size);
        end else if (press[0]) begin
            if (int'(exp_pos.x) + 2 * frog_size <= 640) next_pos.x = exp_pos.x + 10'(frog_size);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            btn_q    <= '0;
            btn_prev <= '0;
            press    <= '0;
            exp_pos  <= start_pos;
            exp_won  <= 1'b0;
        end else begin
            btn_q    <= {button_up, button_down, button_left, button_right};
            btn_prev <= btn_q;
            press    <= btn_q & ~btn_prev;
            if (|press) begin
                if (exp_won) begin
                    exp_pos <= start_pos;   // Restart round
                    exp_won <= 1'b0;
                end else begin
                    exp_pos <= next_pos;
                    exp_won <= (next_pos.y == 10'd0);
                end
            end
        end
    end

    hsync_width: assert property (@(posedge clk) disable iff (!rst_n)
        h_rise |-> h_low_len == 20'd96)
        else begin
            fail_count++;
            $error("hsync low time is not 96 cycles");
        end

    hsync_period: assert property (@(posedge clk) disable iff (!rst_n)
        (h_fall && h_seen) |-> h_gap == 20'd800)
        else begin
            fail_count++;
            $error("hsync period is not 800 cycles");
        end

    vsync_width: assert property (@(posedge clk) disable iff (!rst_n)
        v_rise |-> v_low_len == 20'd1600)
        else begin
            fail_count++;
            $error("vsync low time is not 2 lines");
        end

    vsync_period: assert property (@(posedge clk) disable iff (!rst_n)
        (v_fall && v_seen) |-> v_gap == 20'd420000)
        else begin
            fail_count++;
            $error("vsync period is not 525 lines");
        end

    pos_follows_moves: assert property (@(posedge clk) disable iff (!rst_n)
        frog_pos == exp_pos)
        else begin
            fail_count++;
            $error("frog_pos differs from expected move");
        end

    won_flag: assert property (@(posedge clk) disable iff (!rst_n)
        reached_end == exp_won)
        else begin
            fail_count++;
            $error("reached_end differs from expected");
        end

    still_without_press: assert property (@(posedge clk) disable iff (!rst_n)
        !(|press) |=> $stable(frog_pos))
        else begin
            fail_count++;
            $error("frog moved without a press");
        end

endmodule

bind frogger_top frogger_chk #(
    .init_x    (init_x),
    .init_y    (init_y),
    .frog_size (frog_size)
) u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .button_up    (button_up),
    .button_down  (button_down),
    .button_left  (button_left),
    .button_right (button_right),
    .hsync        (hsync),
    .vsync        (vsync),
    .frog_pos     (frog_pos),
    .reached_end  (reached_end)
);

//--- testbench/tb_frogger.sv
`timescale 1ns/1ns

module tb_frogger;

    import vga_pkg::*;
    import game_pkg::*;

    localparam int dir_up    = 0;
    localparam int dir_down  = 1;
    localparam int dir_left  = 2;
    localparam int dir_right = 3;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        button_up;
    logic        button_down;
    logic        button_left;
    logic        button_right;
    logic        hsync;
    logic        vsync;
    pixel_t      color;
    frog_pos_t   frog_pos;
    logic        reached_end;
    logic [9:0]  shadow_col;
    logic [9:0]  shadow_row;
    logic        shadow_valid;
    int          frames_seen;
    frog_pos_t   pos_at_pixel;   // Frog position the shown pixel was drawn with
    logic [31:0] lcg_state;

    frogger_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .button_up    (button_up),
        .button_down  (button_down),
        .button_left  (button_left),
        .button_right (button_right),
        .hsync        (hsync),
        .vsync        (vsync),
        .color        (color),
        .frog_pos     (frog_pos),
        .reached_end  (reached_end)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic pixel_t expected_color(input logic [9:0] c, input logic [9:0] r,
                                              input frog_pos_t fp);
        if (c >= 640 || r >= 480) return '0;   // Blanking
        if (c >= fp.x && c < fp.x + 32 && r >= fp.y && r < fp.y + 32) return FROG_COLOR;
        if (r < 32 && c % 64 != 0) return GOAL_COLOR;
        if (r >= 224 && r < 448) return ROAD_COLOR;
        return GRASS_COLOR;
    endfunction

    task automatic end_with_failure(input string line);
        $display("%s", line);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped on first error");
    endtask

    task automatic report_mismatch(input string msg);
        end_with_failure($sformatf("Mismatch at %0t ns: %s", $time, msg));
    endtask

    task automatic press_button(input int dir);
        @(posedge clk);
        case (dir)
            dir_up:   button_up   <= 1'b1;
            dir_down: button_down <= 1'b1;
            dir_left: button_left <= 1'b1;
            default:  button_right <= 1'b1;
        endcase
        repeat (3) @(posedge clk);
        button_up    <= 1'b0;
        button_down  <= 1'b0;
        button_left  <= 1'b0;
        button_right <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic wait_for_win();
        int cycles;
        cycles = 0;
        while (!reached_end) begin
            @(posedge clk);
            cycles++;
            if (cycles > 20) end_with_failure("Timeout: frog never reached the top row");
        end
    endtask

    task automatic wait_for_frames(input int count);
        int cycles;
        cycles = 0;
        while (frames_seen < count) begin
            @(posedge clk);
            cycles++;
            if (cycles > count * 420000 + 5000) end_with_failure("Timeout: frames did not complete");
        end
    endtask

    // Shadow scan position of the pixel shown on the ports
    always @(posedge clk) begin
        if (!rst_n) begin
            shadow_valid <= 1'b0;
            shadow_col   <= '0;
            shadow_row   <= '0;
            frames_seen  <= 0;
        end else if (!shadow_valid) begin
            shadow_valid <= 1'b1;
        end else if (shadow_col == 10'd799) begin
            shadow_col <= '0;
            if (shadow_row == 10'd524) begin
                shadow_row  <= '0;
                frames_seen <= frames_seen + 1;
            end else begin
                shadow_row <= shadow_row + 10'd1;
            end
        end else begin
            shadow_col <= shadow_col + 10'd1;
        end
        pos_at_pixel <= frog_pos;
    end

    always @(negedge clk) begin
        if (UUT.u_chk.fail_count != 0) begin
            report_mismatch("a checker assertion failed");
        end else if (shadow_valid) begin
            assert (color == expected_color(shadow_col, shadow_row, pos_at_pixel))
                else report_mismatch($sformatf("color %b at col %0d row %0d", color,
                                               shadow_col, shadow_row));
        end
    end

    initial begin
        lcg_state    = 32'hbd4ffd05;
        rst_n        <= 1'b0;
        button_up    <= 1'b0;
        button_down  <= 1'b0;
        button_left  <= 1'b0;
        button_right <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (frog_pos.x == 10'd320 && frog_pos.y == 10'd448)
            else report_mismatch("frog_pos after reset is not (320, 448)");
        repeat (11) press_button(dir_left);    // Last one hits the left edge
        repeat (20) press_button(dir_right);   // Last one hits the right edge
        press_button(dir_down);                // Blocked at the bottom lane
        repeat (14) press_button(dir_up);
        wait_for_win();
        wait_for_frames(1);                    // Frog drawn over the goal strip
        press_button(dir_left);                // Restart from the start lane
        for (int i = 0; i < 24; i++) begin
            lcg_state = lcg_next(lcg_state);
            press_button(int'(lcg_state[17:16]));
        end
        wait_for_frames(2);
        if (UUT.u_chk.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            report_mismatch("a checker assertion failed");
        end
    end

endmodule

//--- project.f
verilog/vga_pkg.sv
verilog/game_pkg.sv
verilog/vga_timing.sv
verilog/frog_ctrl.sv
verilog/frog_gen.sv
verilog/window_grid.sv
verilog/background.sv
verilog/frogger_top.sv
testbench/frogger_chk.sv
testbench/tb_frogger.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_frogger -f project.f -o sim_frogger &&
./obj_dir/sim_frogger | tee /dev/stderr | grep -q "TEST RESULT: PASS" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
